// File: afe_pkg.sv
// Analog front-end shared definitions
// Sample types, stream structs, bus structs and register map

package afe_pkg;

  //////////////////////////////
  // Sample widths
  //////////////////////////////

  localparam int unsigned ACQ_W = 16;  // Acquired sample, 16-bit ADC
  localparam int unsigned GEN_W = 14;  // Generated sample, DAC width
  localparam int unsigned SUM_W = 15;  // Channel sum, one guard bit

  // Signed stream samples
  typedef logic signed [ACQ_W-1:0] acq_t;
  typedef logic signed [GEN_W-1:0] gen_t;

  //////////////////////////////
  // Stream pairs
  //////////////////////////////

  typedef struct packed {
    acq_t ch_a;  // Channel 1
    acq_t ch_b;  // Channel 2
  } acq_pair_t;

  typedef struct packed {
    gen_t ch_a;
    gen_t ch_b;
  } gen_pair_t;

  // Raw ADC words, unsigned negative slope
  typedef struct packed {
    logic [ACQ_W-1:0] ch_a;
    logic [ACQ_W-1:0] ch_b;
  } raw_pair_t;

  // DAC codes, offset binary negative slope
  typedef struct packed {
    logic [GEN_W-1:0] ch_a;
    logic [GEN_W-1:0] ch_b;
  } dac_pair_t;

  //////////////////////////////
  // System bus
  //////////////////////////////

  typedef struct packed {
    logic [31:0] addr;   // Byte address
    logic [31:0] wdata;  // Write data
    logic        wen;    // Write strobe, one cycle
    logic        ren;    // Read strobe, one cycle
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata;  // Valid with ack
    logic        err;    // Unmapped or read-only target
    logic        ack;    // One cycle after strobe
  } sys_rsp_t;

  // Housekeeping register offsets
  localparam logic [31:0] HK_ID_OFS   = 32'h00;  // Identification, read only
  localparam logic [31:0] HK_LOOP_OFS = 32'h04;  // Digital loopback enable
  localparam logic [31:0] HK_LED_OFS  = 32'h08;  // LED byte

endpackage

// File: afe_hk_regs.sv
// Housekeeping registers
// ID word, loopback enable and LEDs on the system bus

`timescale 1ns/1ps

module afe_hk_regs #(
  parameter int unsigned SYS_AW = 20,             // Decoded address bits
  parameter logic [31:0] HK_ID  = 32'hAFE0_0001   // Identification word
)(
  input  logic                adc_clk,         // System clock
  input  logic                rst_i,           // Sync reset, active high
  input  afe_pkg::sys_req_t   sys_req_i,       // Bus request
  output afe_pkg::sys_rsp_t   sys_rsp_o,       // Bus response
  output logic                digital_loop_o,  // Loopback enable
  output logic [7:0]          led_o            // LED byte
);

  logic [SYS_AW-1:0] ofs;       // Decoded offset
  logic              sel_id;
  logic              sel_loop;
  logic              sel_led;
  logic              mapped;    // Offset hits a register
  logic              strobe;    // Any access this cycle
  logic              err_d;
  logic [31:0]       rdata_d;
  logic              loop_q;    // Loopback bit
  logic [7:0]        led_q;     // LED register
  afe_pkg::sys_rsp_t rsp_q;     // Registered response

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign ofs = sys_req_i.addr[SYS_AW-1:0];  // Upper bits ignored

  assign sel_id   = (ofs == SYS_AW'(afe_pkg::HK_ID_OFS));
  assign sel_loop = (ofs == SYS_AW'(afe_pkg::HK_LOOP_OFS));
  assign sel_led  = (ofs == SYS_AW'(afe_pkg::HK_LED_OFS));
  assign mapped   = sel_id | sel_loop | sel_led;

  assign strobe = sys_req_i.wen | sys_req_i.ren;

  // Unmapped access, or a write to the read-only ID
  assign err_d = strobe & (~mapped | (sys_req_i.wen & sel_id));

  // Read mux, quiet when not reading
  always_comb
  begin
    rdata_d = '0;
    if (sys_req_i.ren)
    begin
      if (sel_id)
        rdata_d = HK_ID;
      else if (sel_loop)
        rdata_d = {31'd0, loop_q};
      else if (sel_led)
        rdata_d = {24'd0, led_q};
    end
  end

  //////////////////////////////
  // Control registers
  //////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      loop_q <= 1'b0;
      led_q  <= '0;
    end
    else if (sys_req_i.wen)
    begin
      if (sel_loop)
        loop_q <= sys_req_i.wdata[0];
      if (sel_led)
        led_q <= sys_req_i.wdata[7:0];
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  // Ack one cycle after the strobe, data and error alongside
  always_ff @(posedge adc_clk)
  begin
    rsp_q.rdata <= rdata_d;
    if (rst_i)
    begin
      rsp_q.ack <= 1'b0;
      rsp_q.err <= 1'b0;
    end
    else
    begin
      rsp_q.ack <= strobe;
      rsp_q.err <= err_d;
    end
  end

  assign sys_rsp_o      = rsp_q;
  assign digital_loop_o = loop_q;
  assign led_o          = led_q;

  // Master side must keep strobes apart
  a_no_rw : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    !(sys_req_i.wen && sys_req_i.ren)
  );

  // Single strobes give single-cycle acks
  a_ack_pulse : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    sys_rsp_o.ack |=> !sys_rsp_o.ack
  );

endmodule

// File: afe_adc_rx.sv
// ADC receive path
// Input register, two's complement conversion, loopback mux

`timescale 1ns/1ps

module afe_adc_rx (
  input  logic                 adc_clk,         // ADC clock
  input  logic                 rst_i,           // Sync reset, active high
  input  afe_pkg::raw_pair_t   adc_dat_i,       // Raw ADC words
  input  afe_pkg::gen_pair_t   loop_dat_i,      // Saturated DAC-side samples
  input  logic                 digital_loop_i,  // Loopback select
  output afe_pkg::acq_pair_t   acq_o            // Acquired stream
);

  localparam int unsigned ACQ_W = afe_pkg::ACQ_W;
  localparam int unsigned GEN_W = afe_pkg::GEN_W;

  // Channel-indexed views of the pairs, ch_a at index 1
  logic [1:0][ACQ_W-1:0] raw_q;  // ADC input register
  afe_pkg::gen_t [1:0]   loop_v;
  afe_pkg::acq_t [1:0]   acq_v;

  assign loop_v = loop_dat_i;

  //////////////////////////////
  // Input register
  //////////////////////////////

  // Mid-scale after reset, which converts to zero
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      raw_q <= {2{1'b0, {(ACQ_W-1){1'b1}}}};
    else
      raw_q <= adc_dat_i;  // Both channels every cycle
  end

  //////////////////////////////
  // Conversion and loopback
  //////////////////////////////

  for (genvar ch = 0; ch < 2; ch++)
  begin : g_ch
    // Negative slope unsigned to two's complement: keep MSB, invert the rest
    // Loopback sample is zero-extended, no sign extension
    assign acq_v[ch] = digital_loop_i ?
                       {{(ACQ_W-GEN_W){1'b0}}, loop_v[ch]} :
                       {raw_q[ch][ACQ_W-1], ~raw_q[ch][ACQ_W-2:0]};
  end

  assign acq_o = acq_v;

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Loop select comes from the register block and must be settled
  a_loop_known : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    !$isunknown(digital_loop_i)
  );

endmodule

// File: afe_dac_tx.sv
// DAC transmit path
// Channel sum, saturation and offset-binary output register

`timescale 1ns/1ps

module afe_dac_tx (
  input  logic                 adc_clk,    // ADC clock, DAC runs on it too
  input  logic                 rst_i,      // Sync reset, active high
  input  afe_pkg::gen_pair_t   asg_i,      // Generator stream
  input  afe_pkg::gen_pair_t   pid_i,      // Controller stream
  output afe_pkg::gen_pair_t   dac_sat_o,  // Saturated sum, combinational
  output afe_pkg::dac_pair_t   dac_dat_o   // Registered DAC codes
);

  localparam int unsigned GEN_W = afe_pkg::GEN_W;
  localparam int unsigned SUM_W = afe_pkg::SUM_W;

  // Channel-indexed views, ch_a at index 1
  afe_pkg::gen_t [1:0]   asg_v;
  afe_pkg::gen_t [1:0]   pid_v;
  afe_pkg::gen_t [1:0]   sat_v;     // Saturated sums
  logic [1:0][SUM_W-1:0] sum_v;     // Raw sums with guard bit
  logic [1:0][GEN_W-1:0] code_q;    // DAC output register
  logic [1:0]            ovf_pos;   // Sum above largest gen_t
  logic [1:0]            ovf_neg;   // Sum below smallest gen_t

  assign asg_v = asg_i;
  assign pid_v = pid_i;

  for (genvar ch = 0; ch < 2; ch++)
  begin : g_ch

    //////////////////////////////
    // Sum and saturation
    //////////////////////////////

    // Sign-extend both operands by one bit
    assign sum_v[ch] = {asg_v[ch][GEN_W-1], asg_v[ch]} +
                       {pid_v[ch][GEN_W-1], pid_v[ch]};

    // Top two bits differ on overflow
    assign ovf_pos[ch] = ~sum_v[ch][SUM_W-1] &  sum_v[ch][SUM_W-2];
    assign ovf_neg[ch] =  sum_v[ch][SUM_W-1] & ~sum_v[ch][SUM_W-2];

    always_comb
    begin
      if (ovf_pos[ch] | ovf_neg[ch])
        sat_v[ch] = {sum_v[ch][SUM_W-1], {(GEN_W-1){~sum_v[ch][SUM_W-1]}}};  // Clamp
      else
        sat_v[ch] = sum_v[ch][GEN_W-1:0];
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    // Offset binary, negative slope: keep MSB, invert the rest
    always_ff @(posedge adc_clk)
    begin
      if (rst_i)
        code_q[ch] <= {1'b0, {(GEN_W-1){1'b1}}};  // Code of zero
      else
        code_q[ch] <= {sat_v[ch][GEN_W-1], ~sat_v[ch][GEN_W-2:0]};
    end

    // Overflow must land on the end codes one cycle later
    a_sat_pos : assert property (
      @(posedge adc_clk) disable iff (rst_i)
      $past(ovf_pos[ch] & ~rst_i) |-> (code_q[ch] == '0)
    );
    a_sat_neg : assert property (
      @(posedge adc_clk) disable iff (rst_i)
      $past(ovf_neg[ch] & ~rst_i) |-> (code_q[ch] == '1)
    );
  end

  assign dac_sat_o = sat_v;   // Feeds the loopback path
  assign dac_dat_o = code_q;

endmodule

// File: afe_top.sv
// Analog front-end top
// Register block beside the ADC and DAC datapath

`timescale 1ns/1ps

module afe_top #(
  parameter int unsigned SYS_AW = 20,             // Decoded address bits
  parameter logic [31:0] HK_ID  = 32'hAFE0_0001   // Identification word
)(
  input  logic                adc_clk,    // ADC clock, whole design
  input  logic                rst_i,      // Sync reset, active high
  // ADC
  input  afe_pkg::raw_pair_t  adc_dat_i,  // Raw ADC words
  // Streams in
  input  afe_pkg::gen_pair_t  asg_i,      // Generator samples
  input  afe_pkg::gen_pair_t  pid_i,      // Controller samples
  // System bus
  input  afe_pkg::sys_req_t   sys_req_i,
  output afe_pkg::sys_rsp_t   sys_rsp_o,
  // Streams out
  output afe_pkg::acq_pair_t  acq_o,      // Acquired samples
  output afe_pkg::dac_pair_t  dac_dat_o,  // DAC codes, both channels
  // LED
  output logic [7:0]          led_o
);

  logic               digital_loop;  // Loopback enable from housekeeping
  afe_pkg::gen_pair_t dac_sat;       // Saturated sums, loopback source

  //////////////////////////////
  // Housekeeping
  //////////////////////////////

  afe_hk_regs #(
    .SYS_AW (SYS_AW),
    .HK_ID  (HK_ID)
  ) i_hk (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .sys_req_i      (sys_req_i),
    .sys_rsp_o      (sys_rsp_o),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  //////////////////////////////
  // ADC path
  //////////////////////////////

  afe_adc_rx i_adc_rx (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_dat_i      (adc_dat_i),
    .loop_dat_i     (dac_sat),       // Same-cycle DAC samples
    .digital_loop_i (digital_loop),
    .acq_o          (acq_o)
  );

  //////////////////////////////
  // DAC path
  //////////////////////////////

  afe_dac_tx i_dac_tx (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .asg_i     (asg_i),
    .pid_i     (pid_i),
    .dac_sat_o (dac_sat),
    .dac_dat_o (dac_dat_o)   // One cycle after asg_i, pid_i
  );

endmodule

// File: afe_tb.sv
// Analog front-end testbench
// Reference rules and concurrent checks on afe_top

`timescale 1ns/1ps

module afe_tb;

  localparam int unsigned SYS_AW      = 16;             // Narrower than default
  localparam logic [31:0] HK_ID       = 32'h5EED_0A1F;
  localparam int          ACK_TIMEOUT = 16;             // Cycles per bus access
  localparam int          GEN_MAX     = 8191;           // Largest 14-bit sample
  localparam int          GEN_MIN     = -8192;

  logic                adc_clk = 1'b0;
  logic                rst_i;
  afe_pkg::raw_pair_t  adc_dat_i;
  afe_pkg::gen_pair_t  asg_i;
  afe_pkg::gen_pair_t  pid_i;
  afe_pkg::sys_req_t   sys_req_i;
  afe_pkg::sys_rsp_t   sys_rsp_o;
  afe_pkg::acq_pair_t  acq_o;
  afe_pkg::dac_pair_t  dac_dat_o;
  logic [7:0]          led_o;
  logic                loop_mdl;  // Expected loopback bit
  logic [7:0]          led_mdl;   // Expected LED byte

  always #5 adc_clk = ~adc_clk;  // 10 ns

  afe_top #(
    .SYS_AW (SYS_AW),
    .HK_ID  (HK_ID)
  ) dut0 (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .adc_dat_i (adc_dat_i),
    .asg_i     (asg_i),
    .pid_i     (pid_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .acq_o     (acq_o),
    .dac_dat_o (dac_dat_o),
    .led_o     (led_o)
  );

  //////////////////////////////
  // Reference rules
  //////////////////////////////

  // Negative slope, 0x0000 is positive full scale
  function automatic afe_pkg::acq_t convert_word(logic [15:0] raw);
    return afe_pkg::acq_t'(32767 - int'(raw));
  endfunction

  function automatic afe_pkg::gen_t saturate_sum(afe_pkg::gen_t a, afe_pkg::gen_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > GEN_MAX)
      s = GEN_MAX;  // Clamp high
    else if (s < GEN_MIN)
      s = GEN_MIN;  // Clamp low
    return afe_pkg::gen_t'(s);
  endfunction

  // Offset binary, negative slope, zero lands on 0x1FFF
  function automatic logic [13:0] offset_code(afe_pkg::gen_t s);
    return 14'(8191 - int'(s));
  endfunction

  function automatic afe_pkg::acq_pair_t expect_acq(afe_pkg::raw_pair_t r);
    afe_pkg::acq_pair_t p;
    p.ch_a = convert_word(r.ch_a);
    p.ch_b = convert_word(r.ch_b);
    return p;
  endfunction

  // Loopback sample, zero-extended
  function automatic afe_pkg::acq_pair_t expect_loop(afe_pkg::gen_pair_t a,
                                                     afe_pkg::gen_pair_t b);
    afe_pkg::acq_pair_t p;
    p.ch_a = {2'b00, saturate_sum(a.ch_a, b.ch_a)};
    p.ch_b = {2'b00, saturate_sum(a.ch_b, b.ch_b)};
    return p;
  endfunction

  function automatic afe_pkg::dac_pair_t expect_dac(afe_pkg::gen_pair_t a,
                                                    afe_pkg::gen_pair_t b);
    afe_pkg::dac_pair_t p;
    p.ch_a = offset_code(saturate_sum(a.ch_a, b.ch_a));
    p.ch_b = offset_code(saturate_sum(a.ch_b, b.ch_b));
    return p;
  endfunction

  // Register map, low SYS_AW address bits only
  function automatic logic is_mapped(logic [31:0] addr);
    logic [SYS_AW-1:0] ofs;
    ofs = addr[SYS_AW-1:0];
    return (ofs == SYS_AW'(afe_pkg::HK_ID_OFS)) || (ofs == SYS_AW'(afe_pkg::HK_LOOP_OFS)) ||
           (ofs == SYS_AW'(afe_pkg::HK_LED_OFS));
  endfunction

  function automatic logic expect_err(afe_pkg::sys_req_t r);
    if (!(r.wen || r.ren))
      return 1'b0;  // No access, no error
    if (!is_mapped(r.addr))
      return 1'b1;
    return r.wen && (r.addr[SYS_AW-1:0] == SYS_AW'(afe_pkg::HK_ID_OFS));  // ID is read only
  endfunction

  function automatic logic [31:0] expect_rdata(logic [31:0] addr, logic loop_bit,
                                               logic [7:0] led_byte);
    logic [SYS_AW-1:0] ofs;
    ofs = addr[SYS_AW-1:0];
    if (ofs == SYS_AW'(afe_pkg::HK_ID_OFS))
      return HK_ID;
    if (ofs == SYS_AW'(afe_pkg::HK_LOOP_OFS))
      return {31'd0, loop_bit};
    return {24'd0, led_byte};
  endfunction

  // Register effect one cycle after the write
  always @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      loop_mdl <= 1'b0;
      led_mdl  <= 8'd0;
    end
    else if (sys_req_i.wen)
    begin
      if (sys_req_i.addr[SYS_AW-1:0] == SYS_AW'(afe_pkg::HK_LOOP_OFS))
        loop_mdl <= sys_req_i.wdata[0];
      if (sys_req_i.addr[SYS_AW-1:0] == SYS_AW'(afe_pkg::HK_LED_OFS))
        led_mdl <= sys_req_i.wdata[7:0];
    end
  end

  task automatic report_mismatch(string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "run stopped on a failed check");
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_reset_state : assert property (@(posedge adc_clk) disable iff (rst_i)
    $past(rst_i) |-> (!sys_rsp_o.ack && !sys_rsp_o.err && led_o == 8'd0 &&
                      acq_o == '0 && dac_dat_o == {2{14'h1FFF}}))
    else report_mismatch("outputs wrong in the first cycle after reset");

  a_convert : assert property (@(posedge adc_clk) disable iff (rst_i)
    (!loop_mdl && !$past(rst_i)) |-> (acq_o == expect_acq($past(adc_dat_i))))
    else report_mismatch("acq_o does not follow the ADC conversion");

  a_loopback : assert property (@(posedge adc_clk) disable iff (rst_i)
    loop_mdl |-> (acq_o == expect_loop(asg_i, pid_i)))
    else report_mismatch("acq_o does not carry the loopback sum");

  a_dac : assert property (@(posedge adc_clk) disable iff (rst_i)
    !$past(rst_i) |-> (dac_dat_o == expect_dac($past(asg_i), $past(pid_i))))
    else report_mismatch("dac_dat_o differs from the saturated sum code");

  a_ack : assert property (@(posedge adc_clk) disable iff (rst_i)
    !$past(rst_i) |-> (sys_rsp_o.ack == $past(sys_req_i.wen || sys_req_i.ren)))
    else report_mismatch("ack not one cycle after the strobe");

  a_err : assert property (@(posedge adc_clk) disable iff (rst_i)
    !$past(rst_i) |-> (sys_rsp_o.err == $past(expect_err(sys_req_i))))
    else report_mismatch("err flag wrong");

  a_rdata : assert property (@(posedge adc_clk) disable iff (rst_i)
    (sys_rsp_o.ack && $past(sys_req_i.ren && is_mapped(sys_req_i.addr))) |->
    (sys_rsp_o.rdata == $past(expect_rdata(sys_req_i.addr, loop_mdl, led_mdl))))
    else report_mismatch("read data wrong");

  a_led : assert property (@(posedge adc_clk) disable iff (rst_i)
    led_o == led_mdl)
    else report_mismatch("led_o differs from the last written byte");

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Extremes one time in two, random otherwise
  function automatic afe_pkg::gen_t pick_gen();
    case ($urandom % 8)
      0: return afe_pkg::gen_t'(GEN_MAX);
      1: return afe_pkg::gen_t'(GEN_MIN);
      2: return '0;
      3: return '1;  // Minus one
      default: return afe_pkg::gen_t'($urandom);
    endcase
  endfunction

  function automatic logic [15:0] pick_raw();
    case ($urandom % 8)
      0: return 16'h0000;
      1: return 16'hFFFF;
      2: return 16'h7FFF;  // Mid-scale
      3: return 16'h8000;
      default: return 16'($urandom);
    endcase
  endfunction

  // One sample per cycle on every stream
  task automatic next_cycle();
    @(posedge adc_clk);
    adc_dat_i.ch_a <= pick_raw();
    adc_dat_i.ch_b <= pick_raw();
    asg_i.ch_a     <= pick_gen();
    asg_i.ch_b     <= pick_gen();
    pid_i.ch_a     <= pick_gen();
    pid_i.ch_b     <= pick_gen();
  endtask

  task automatic bus_access(logic [31:0] addr, logic [31:0] data, logic write);
    int waited;
    next_cycle();
    sys_req_i.addr  <= addr;
    sys_req_i.wdata <= data;
    sys_req_i.wen   <= write;
    sys_req_i.ren   <= !write;
    next_cycle();
    sys_req_i.wen <= 1'b0;  // Single-cycle strobe
    sys_req_i.ren <= 1'b0;
    waited = 0;
    @(negedge adc_clk);
    while (!sys_rsp_o.ack && waited < ACK_TIMEOUT)
    begin
      waited++;
      next_cycle();
      @(negedge adc_clk);
    end
    if (!sys_rsp_o.ack)
    begin
      $display("Timeout: no bus ack for address %h", addr);
      $display("Some tests failed");
      $fatal(1, "bus ack timeout");
    end
  endtask

  initial
  begin
    void'($urandom(88640));
    rst_i     = 1'b1;
    adc_dat_i = '0;
    asg_i     = '0;
    pid_i     = '0;
    sys_req_i = '0;
    repeat (2) @(posedge adc_clk);
    rst_i <= 1'b0;
    repeat (200) next_cycle();                    // Conversion and DAC path
    bus_access(afe_pkg::HK_LED_OFS, 32'hA5, 1'b1);
    bus_access(afe_pkg::HK_LED_OFS, 32'h0, 1'b0);
    bus_access(afe_pkg::HK_ID_OFS, 32'h0, 1'b0);
    bus_access(afe_pkg::HK_LOOP_OFS, 32'h0, 1'b0);
    bus_access(afe_pkg::HK_ID_OFS, 32'h1234, 1'b1);  // Read-only target
    bus_access(32'h0000_000C, 32'h0, 1'b0);          // Unmapped read
    bus_access(32'h0000_0040, 32'hFF, 1'b1);         // Unmapped write
    bus_access(32'h0001_0008, 32'h3C, 1'b1);         // Upper bits ignored
    bus_access(afe_pkg::HK_LED_OFS, 32'h0, 1'b0);
    bus_access(afe_pkg::HK_LOOP_OFS, 32'h1, 1'b1);
    bus_access(afe_pkg::HK_LOOP_OFS, 32'h0, 1'b0);
    repeat (200) next_cycle();                    // Loopback active
    bus_access(afe_pkg::HK_LOOP_OFS, 32'h0, 1'b1);
    repeat (100) next_cycle();                    // Back to conversion
    $display("All tests passed");
    $finish;
  end

  // Overall time limit
  initial
  begin
    #100000;
    $display("Simulation ran past its time limit");
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: afe.f
afe_pkg.sv
afe_hk_regs.sv
afe_adc_rx.sv
afe_dac_tx.sv
afe_top.sv
afe_tb.sv

// File: Makefile
# Verilator build for the analog front-end testbench

VERILATOR ?= verilator
TOP       ?= afe_tb
FILELIST  ?= afe.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=

SRCS := $(filter %.sv,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
